// File: eth_stats_top.f
verilog/eth_stats_pkg.sv
verilog/stats_if.sv
verilog/dir_frame_counter.sv
verilog/stats_regs_wb.sv
verilog/eth_stats_top.sv
verification/eth_stats_props.sv
verification/eth_stats_tb.sv

// File: Makefile
# Verilator build and run for the Ethernet statistics collector

VERILATOR ?= verilator
TOP ?= eth_stats_tb
FILELIST ?= eth_stats_top.f
BUILD_DIR ?= build
LOG ?= $(BUILD_DIR)/sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= >>> PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   compile with Verilator, run the testbench and check the log"
	@echo "  clean  remove build output"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR)

// File: verification/eth_stats_tb.sv
// Directed testbench for the Ethernet statistics collector over Wishbone
`timescale 1ns/1ps

module eth_stats_tb;

	localparam int max_frames = 120;
	localparam int max_accesses = 110;
	localparam int item_cycles = 8;

	logic clk;
	logic rst_n;
	logic tx_frame_done, tx_frame_ok, rx_frame_done, rx_frame_ok;
	logic [eth_stats_pkg::len_w-1:0] tx_frame_len, rx_frame_len;
	logic wb_cyc, wb_stb, wb_we, wb_ack, wb_err;
	logic [eth_stats_pkg::adr_w-1:0] wb_adr;
	logic [eth_stats_pkg::cnt_w-1:0] wb_dat_w, wb_dat_r;
	logic [3:0] wb_sel;

	// Expected totals in order tx bytes, good, bad and the same for rx
	logic [eth_stats_pkg::cnt_w-1:0] model [6];
	logic [eth_stats_pkg::cnt_w-1:0] saved [6];
	logic [eth_stats_pkg::cnt_w-1:0] model_ctrl;
	logic [31:0] rng_state;

	eth_stats_top dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Bound from the item counts plus the reset time
	initial begin
		#((max_frames + max_accesses) * item_cycles * 20 + 8 * 20);
		fail_run("Timeout: the tests did not finish in the expected time");
	end

	function automatic logic [31:0] next_random();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	function automatic logic [eth_stats_pkg::len_w-1:0] random_len();
		return 16'(32'd64 + next_random() % 32'd1455);
	endfunction

	function automatic logic random_ok();
		return (next_random() % 32'd8) != 0;
	endfunction

	task automatic fail_run(input string line);
		$display("%s", line);
		$display(">>> FAIL");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic check_word(input string what, input logic [eth_stats_pkg::cnt_w-1:0] got,
			input logic [eth_stats_pkg::cnt_w-1:0] exp);
		if (got !== exp)
			fail_run($sformatf("[ERROR] %0t: %s read 0x%08h, expected 0x%08h",
				$time, what, got, exp));
	endtask

	task automatic check_resp(input string what, input eth_stats_pkg::wb_resp_e got,
			input eth_stats_pkg::wb_resp_e exp);
		if (got !== exp)
			fail_run($sformatf("[ERROR] %0t: %s gave %s, expected %s",
				$time, what, got.name(), exp.name()));
	endtask

	// Master holds the request of one classic cycle until ack or err
	task automatic bus_cycle(input logic we, input logic [eth_stats_pkg::adr_w-1:0] adr,
			input logic [eth_stats_pkg::cnt_w-1:0] wdata, input logic [3:0] sel,
			output logic [eth_stats_pkg::cnt_w-1:0] rdata,
			output eth_stats_pkg::wb_resp_e resp);
		@(posedge clk);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= we;
		wb_adr <= adr;
		wb_dat_w <= wdata;
		wb_sel <= sel;
		@(negedge clk);
		while (!wb_ack && !wb_err)
			@(negedge clk);
		rdata = wb_dat_r;
		resp = wb_err ? eth_stats_pkg::resp_err : eth_stats_pkg::resp_ack;
		@(posedge clk);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we <= 1'b0;
	endtask

	task automatic wb_write(input logic [eth_stats_pkg::adr_w-1:0] adr,
			input logic [eth_stats_pkg::cnt_w-1:0] data, input logic [3:0] sel,
			output eth_stats_pkg::wb_resp_e resp);
		logic [eth_stats_pkg::cnt_w-1:0] unused;
		bus_cycle(1'b1, adr, data, sel, unused, resp);
	endtask

	task automatic wb_read(input logic [eth_stats_pkg::adr_w-1:0] adr,
			output logic [eth_stats_pkg::cnt_w-1:0] data,
			output eth_stats_pkg::wb_resp_e resp);
		bus_cycle(1'b0, adr, '0, 4'hF, data, resp);
	endtask

	task automatic read_expect(input logic [eth_stats_pkg::adr_w-1:0] adr,
			input logic [eth_stats_pkg::cnt_w-1:0] exp, input string what);
		logic [eth_stats_pkg::cnt_w-1:0] data;
		eth_stats_pkg::wb_resp_e resp;
		wb_read(adr, data, resp);
		check_resp(what, resp, eth_stats_pkg::resp_ack);
		check_word(what, data, exp);
	endtask

	// Soft reset masks enable and hold and empties the totals
	task automatic set_ctrl(input logic [eth_stats_pkg::cnt_w-1:0] value);
		eth_stats_pkg::wb_resp_e resp;
		wb_write(eth_stats_pkg::reg_ctrl, value, 4'hF, resp);
		check_resp("control write", resp, eth_stats_pkg::resp_ack);
		model_ctrl = '0;
		model_ctrl[1] = value[1];
		model_ctrl[0] = value[0] & ~value[1];
		model_ctrl[2] = value[2] & ~value[1];
		if (value[1])
			foreach (model[i]) model[i] = '0;
	endtask

	task automatic compare_counts(input logic use_saved);
		logic [eth_stats_pkg::adr_w-1:0] adr;
		for (int i = 0; i < 6; i++) begin
			adr = 8'h08 + 8'(4 * i);
			read_expect(adr, use_saved ? saved[i] : model[i],
				$sformatf("counter at 0x%02h", adr));
		end
	endtask

	task automatic count_frame(input int side, input logic [15:0] len, input logic ok);
		if (model_ctrl[0]) begin
			model[side * 3] = model[side * 3] + 32'(len);
			if (ok)
				model[side * 3 + 1] = model[side * 3 + 1] + 1;
			else
				model[side * 3 + 2] = model[side * 3 + 2] + 1;
		end
	endtask

	task automatic send_tx(input logic [15:0] len, input logic ok);
		@(posedge clk);
		tx_frame_done <= 1'b1;
		tx_frame_len <= len;
		tx_frame_ok <= ok;
		@(posedge clk);
		tx_frame_done <= 1'b0;
		count_frame(0, len, ok);
	endtask

	task automatic send_rx(input logic [15:0] len, input logic ok);
		@(posedge clk);
		rx_frame_done <= 1'b1;
		rx_frame_len <= len;
		rx_frame_ok <= ok;
		@(posedge clk);
		rx_frame_done <= 1'b0;
		count_frame(1, len, ok);
	endtask

	task automatic send_both(input logic [15:0] tlen, input logic tok,
			input logic [15:0] rlen, input logic rok);
		@(posedge clk);
		tx_frame_done <= 1'b1;
		tx_frame_len <= tlen;
		tx_frame_ok <= tok;
		rx_frame_done <= 1'b1;
		rx_frame_len <= rlen;
		rx_frame_ok <= rok;
		@(posedge clk);
		tx_frame_done <= 1'b0;
		rx_frame_done <= 1'b0;
		count_frame(0, tlen, tok);
		count_frame(1, rlen, rok);
	endtask

	// Let the counter and snapshot stages catch up
	task automatic settle();
		repeat (3) @(posedge clk);
	endtask

	task automatic reset_values_read_zero();
		read_expect(eth_stats_pkg::reg_ctrl, '0, "control after reset");
		read_expect(eth_stats_pkg::reg_time, '0, "timestamp after reset");
		compare_counts(1'b0);
	endtask

	task automatic totals_follow_frames();
		logic [31:0] r;
		send_tx(random_len(), 1'b1);
		send_rx(random_len(), 1'b0);
		send_both(random_len(), 1'b1, random_len(), 1'b1);
		settle();
		compare_counts(1'b0);
		set_ctrl(32'h1);
		for (int i = 0; i < 30; i++) begin
			r = next_random();
			case (r[1:0])
				2'd0: send_tx(random_len(), random_ok());
				2'd1: send_rx(random_len(), random_ok());
				default: send_both(random_len(), random_ok(), random_len(), random_ok());
			endcase
		end
		settle();
		read_expect(eth_stats_pkg::reg_ctrl, model_ctrl, "control while enabled");
		compare_counts(1'b0);
	endtask

	task automatic timestamp_advances();
		logic [eth_stats_pkg::cnt_w-1:0] t_first, t_second;
		eth_stats_pkg::wb_resp_e resp;
		send_tx(16'd200, 1'b1);
		settle();
		wb_read(eth_stats_pkg::reg_time, t_first, resp);
		check_resp("first timestamp read", resp, eth_stats_pkg::resp_ack);
		repeat (5) @(posedge clk);
		send_rx(16'd300, 1'b1);
		settle();
		wb_read(eth_stats_pkg::reg_time, t_second, resp);
		check_resp("second timestamp read", resp, eth_stats_pkg::resp_ack);
		if (!(t_second > t_first))
			fail_run($sformatf("[ERROR] %0t: timestamp 0x%08h did not pass 0x%08h",
				$time, t_second, t_first));
		compare_counts(1'b0);
	endtask

	task automatic hold_freezes_snapshot();
		logic [eth_stats_pkg::cnt_w-1:0] t_held;
		eth_stats_pkg::wb_resp_e resp;
		foreach (model[i]) saved[i] = model[i];
		set_ctrl(32'h5);
		read_expect(eth_stats_pkg::reg_ctrl, model_ctrl, "control with hold");
		wb_read(eth_stats_pkg::reg_time, t_held, resp);
		check_resp("timestamp before held frames", resp, eth_stats_pkg::resp_ack);
		repeat (4) send_both(random_len(), random_ok(), random_len(), random_ok());
		settle();
		read_expect(eth_stats_pkg::reg_time, t_held, "timestamp with hold");
		compare_counts(1'b1);
		set_ctrl(32'h1);
		send_tx(random_len(), 1'b1);
		settle();
		compare_counts(1'b0);
	endtask

	task automatic soft_reset_clears();
		set_ctrl(32'h3);
		settle();
		read_expect(eth_stats_pkg::reg_ctrl, model_ctrl, "control in soft reset");
		read_expect(eth_stats_pkg::reg_time, '0, "timestamp in soft reset");
		compare_counts(1'b0);
		send_both(random_len(), 1'b1, random_len(), 1'b0);
		settle();
		compare_counts(1'b0);
		set_ctrl(32'h0);
		set_ctrl(32'h1);
		send_tx(random_len(), random_ok());
		send_rx(random_len(), random_ok());
		send_both(random_len(), random_ok(), random_len(), random_ok());
		settle();
		compare_counts(1'b0);
	endtask

	task automatic bad_accesses_err();
		logic [eth_stats_pkg::cnt_w-1:0] data;
		eth_stats_pkg::wb_resp_e resp;
		wb_read(8'h20, data, resp);
		check_resp("read of 0x20", resp, eth_stats_pkg::resp_err);
		wb_read(8'h03, data, resp);
		check_resp("read of 0x03", resp, eth_stats_pkg::resp_err);
		wb_read(8'hFC, data, resp);
		check_resp("read of 0xFC", resp, eth_stats_pkg::resp_err);
		wb_write(eth_stats_pkg::reg_tx_bytes, 32'hFFFF, 4'hF, resp);
		check_resp("write to tx bytes", resp, eth_stats_pkg::resp_err);
		wb_write(eth_stats_pkg::reg_rx_bad, 32'h1234, 4'hF, resp);
		check_resp("write to rx bad", resp, eth_stats_pkg::resp_err);
		compare_counts(1'b0);
		// Lane 0 carries every control bit
		wb_write(eth_stats_pkg::reg_ctrl, 32'h0, 4'b1110, resp);
		check_resp("control write without lane 0", resp, eth_stats_pkg::resp_ack);
		read_expect(eth_stats_pkg::reg_ctrl, model_ctrl, "control after lane 0 masked");
	endtask

	initial begin
		rng_state = 32'h2558;
		rst_n = 1'b0;
		tx_frame_done = 1'b0;
		tx_frame_len = '0;
		tx_frame_ok = 1'b0;
		rx_frame_done = 1'b0;
		rx_frame_len = '0;
		rx_frame_ok = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		wb_sel = '0;
		model_ctrl = '0;
		foreach (model[i]) model[i] = '0;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		reset_values_read_zero();
		totals_follow_frames();
		timestamp_advances();
		hold_freezes_snapshot();
		soft_reset_clears();
		bad_accesses_err();
		$display(">>> PASS");
		$finish;
	end

endmodule

// File: verification/eth_stats_props.sv
// Wishbone response checks for the statistics register block
`timescale 1ns/1ps

module eth_stats_props (
	input logic clk,
	input logic rst_n,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_ack,
	input logic wb_err
);

	// One response kind at a time
	ack_err_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(wb_ack && wb_err))
		else $error("wb_ack and wb_err are high together");

	// Response only to a request sampled one edge earlier
	resp_after_request: assert property (@(posedge clk) disable iff (!rst_n)
		(wb_ack || wb_err) |-> $past(wb_cyc && wb_stb))
		else $error("response without a request in the previous cycle");

	resp_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		(wb_ack || wb_err) |=> !(wb_ack || wb_err))
		else $error("response held for more than one cycle");

endmodule

bind stats_regs_wb eth_stats_props props_i (
	.clk(clk),
	.rst_n(rst_n),
	.wb_cyc(wb_cyc),
	.wb_stb(wb_stb),
	.wb_ack(wb_ack),
	.wb_err(wb_err)
);

// File: verilog/eth_stats_top.sv
// Ethernet statistics collector top with TX and RX counters behind a Wishbone slave
`timescale 1ns/1ps

module eth_stats_top (
	input logic clk,
	input logic rst_n,

	// Transmit side
	input logic tx_frame_done,
	input logic [eth_stats_pkg::len_w-1:0] tx_frame_len,
	input logic tx_frame_ok,

	// Receive side
	input logic rx_frame_done,
	input logic [eth_stats_pkg::len_w-1:0] rx_frame_len,
	input logic rx_frame_ok,

	// Wishbone classic
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [eth_stats_pkg::adr_w-1:0] wb_adr,
	input logic [eth_stats_pkg::cnt_w-1:0] wb_dat_w,
	input logic [3:0] wb_sel,
	output logic [eth_stats_pkg::cnt_w-1:0] wb_dat_r,
	output logic wb_ack,
	output logic wb_err
);

	stats_if tx_stats ();
	stats_if rx_stats ();

	dir_frame_counter tx_counter_i (
		.clk(clk),
		.rst_n(rst_n),
		.frame_done(tx_frame_done),
		.frame_len(tx_frame_len),
		.frame_ok(tx_frame_ok),
		.cnt(tx_stats.counter)
	);

	dir_frame_counter rx_counter_i (
		.clk(clk),
		.rst_n(rst_n),
		.frame_done(rx_frame_done),
		.frame_len(rx_frame_len),
		.frame_ok(rx_frame_ok),
		.cnt(rx_stats.counter)
	);

	stats_regs_wb regs_i (
		.clk(clk),
		.rst_n(rst_n),
		.tx(tx_stats.regs),
		.rx(rx_stats.regs),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_sel(wb_sel),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.wb_err(wb_err)
	);

endmodule

// File: verilog/stats_regs_wb.sv
// Wishbone classic register block with control word, timestamp and counter snapshot
`timescale 1ns/1ps

module stats_regs_wb (
	input logic clk,
	input logic rst_n,

	stats_if.regs tx,
	stats_if.regs rx,

	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [eth_stats_pkg::adr_w-1:0] wb_adr,
	input logic [eth_stats_pkg::cnt_w-1:0] wb_dat_w,
	input logic [3:0] wb_sel,
	output logic [eth_stats_pkg::cnt_w-1:0] wb_dat_r,
	output logic wb_ack,
	output logic wb_err
);

	// Control bits
	logic enable;
	logic srst;
	logic hold;
	logic [eth_stats_pkg::cnt_w-1:0] ctrl_word;

	// Free-running cycle count
	logic [eth_stats_pkg::cnt_w-1:0] time_cnt;

	// Coherent snapshot
	logic [eth_stats_pkg::cnt_w-1:0] snap_time;
	logic [eth_stats_pkg::cnt_w-1:0] snap_tx_bytes, snap_tx_good, snap_tx_bad;
	logic [eth_stats_pkg::cnt_w-1:0] snap_rx_bytes, snap_rx_good, snap_rx_bad;

	// Bus decode
	logic req;
	logic addr_ok;
	logic ctrl_wr;
	logic [eth_stats_pkg::cnt_w-1:0] rd_data;
	eth_stats_pkg::wb_resp_e resp;

	// New request only while no response is on the bus
	assign req = wb_cyc & wb_stb & ~wb_ack & ~wb_err;
	assign ctrl_wr = req & wb_we & wb_sel[0] & (wb_adr == eth_stats_pkg::reg_ctrl);

	assign tx.enable = enable;
	assign rx.enable = enable;
	assign tx.clear = srst;
	assign rx.clear = srst;

	always_comb begin
		ctrl_word = '0;
		ctrl_word[eth_stats_pkg::ctrl_enable_bit] = enable;
		ctrl_word[eth_stats_pkg::ctrl_srst_bit] = srst;
		ctrl_word[eth_stats_pkg::ctrl_hold_bit] = hold;
	end

	// Address decode and read mux
	always_comb begin
		rd_data = '0;
		addr_ok = 1'b1;
		case (wb_adr)
			eth_stats_pkg::reg_ctrl: rd_data = ctrl_word;
			eth_stats_pkg::reg_time: rd_data = snap_time;
			eth_stats_pkg::reg_tx_bytes: rd_data = snap_tx_bytes;
			eth_stats_pkg::reg_tx_good: rd_data = snap_tx_good;
			eth_stats_pkg::reg_tx_bad: rd_data = snap_tx_bad;
			eth_stats_pkg::reg_rx_bytes: rd_data = snap_rx_bytes;
			eth_stats_pkg::reg_rx_good: rd_data = snap_rx_good;
			eth_stats_pkg::reg_rx_bad: rd_data = snap_rx_bad;
			default: addr_ok = 1'b0;
		endcase

		// Only the control word is writable
		if (addr_ok && (!wb_we || wb_adr == eth_stats_pkg::reg_ctrl)) begin
			resp = eth_stats_pkg::resp_ack;
		end else begin
			resp = eth_stats_pkg::resp_err;
		end
	end

	// Control word with soft reset still writable while set
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			enable <= 1'b0;
			srst <= 1'b0;
			hold <= 1'b0;
		end else if (ctrl_wr) begin
			srst <= wb_dat_w[eth_stats_pkg::ctrl_srst_bit];
			enable <= wb_dat_w[eth_stats_pkg::ctrl_enable_bit]
				& ~wb_dat_w[eth_stats_pkg::ctrl_srst_bit];
			hold <= wb_dat_w[eth_stats_pkg::ctrl_hold_bit]
				& ~wb_dat_w[eth_stats_pkg::ctrl_srst_bit];
		end else if (srst) begin
			enable <= 1'b0;
			hold <= 1'b0;
		end
	end

	// Timestamp and snapshot
	always_ff @(posedge clk) begin
		if (!rst_n || srst) begin
			time_cnt <= '0;
			snap_time <= '0;
			snap_tx_bytes <= '0;
			snap_tx_good <= '0;
			snap_tx_bad <= '0;
			snap_rx_bytes <= '0;
			snap_rx_good <= '0;
			snap_rx_bad <= '0;
		end else begin
			time_cnt <= time_cnt + 1'b1;

			if ((tx.changed || rx.changed) && !hold) begin
				snap_time <= time_cnt;
				snap_tx_bytes <= tx.bytes;
				snap_tx_good <= tx.good;
				snap_tx_bad <= tx.bad;
				snap_rx_bytes <= rx.bytes;
				snap_rx_good <= rx.good;
				snap_rx_bad <= rx.bad;
			end
		end
	end

	// One-cycle response
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_ack <= 1'b0;
			wb_err <= 1'b0;
		end else begin
			wb_ack <= req && (resp == eth_stats_pkg::resp_ack);
			wb_err <= req && (resp == eth_stats_pkg::resp_err);
		end
	end

	// Read data
	always_ff @(posedge clk) begin
		if (req && !wb_we) begin
			wb_dat_r <= rd_data;
		end
	end

endmodule

// File: verilog/dir_frame_counter.sv
// Per-direction frame statistics: byte total, good frames and bad frames
`timescale 1ns/1ps

module dir_frame_counter (
	input logic clk,
	input logic rst_n,

	// End-of-frame strobe from the MAC
	input logic frame_done,
	input logic [eth_stats_pkg::len_w-1:0] frame_len,
	input logic frame_ok,

	stats_if.counter cnt
);

	// Frame length widened to counter size
	logic [eth_stats_pkg::cnt_w-1:0] len_ext;

	// Strobe that actually counts
	logic count_en;

	assign len_ext = {{(eth_stats_pkg::cnt_w - eth_stats_pkg::len_w){1'b0}}, frame_len};
	assign count_en = cnt.enable & frame_done;

	always_ff @(posedge clk) begin
		if (!rst_n || cnt.clear) begin
			cnt.bytes <= '0;
			cnt.good <= '0;
			cnt.bad <= '0;
			cnt.changed <= 1'b0;
		end else begin
			cnt.changed <= 1'b0;

			if (count_en) begin
				cnt.bytes <= cnt.bytes + len_ext;

				// Classification comes straight from the MAC status
				if (frame_ok) begin
					cnt.good <= cnt.good + 1'b1;
				end else begin
					cnt.bad <= cnt.bad + 1'b1;
				end

				// Totals move in this same edge
				cnt.changed <= 1'b1;
			end
		end
	end

endmodule

// File: verilog/stats_if.sv
// Link between a direction counter and the register block
`timescale 1ns/1ps

interface stats_if;

	// Running totals from the counter
	logic [eth_stats_pkg::cnt_w-1:0] bytes;
	logic [eth_stats_pkg::cnt_w-1:0] good;
	logic [eth_stats_pkg::cnt_w-1:0] bad;

	// High for one cycle when the totals move
	logic changed;

	// Controls from the register block
	logic enable;
	logic clear;

	modport counter (
		output bytes, good, bad, changed,
		input enable, clear
	);

	modport regs (
		input bytes, good, bad, changed,
		output enable, clear
	);

endinterface

// File: verilog/eth_stats_pkg.sv
// Ethernet statistics collector shared widths, register map and bus result codes
package eth_stats_pkg;

	// Counter, timestamp and data bus width
	localparam int cnt_w = 32;

	// Frame length as reported by the MAC
	localparam int len_w = 16;

	// Wishbone byte address width
	localparam int adr_w = 8;

	// Control word bit positions
	localparam int ctrl_enable_bit = 0;
	localparam int ctrl_srst_bit = 1;
	localparam int ctrl_hold_bit = 2;

	// Register offsets one word apart
	typedef enum logic [adr_w-1:0] {
		reg_ctrl = 8'h00,
		reg_time = 8'h04,
		reg_tx_bytes = 8'h08,
		reg_tx_good = 8'h0C,
		reg_tx_bad = 8'h10,
		reg_rx_bytes = 8'h14,
		reg_rx_good = 8'h18,
		reg_rx_bad = 8'h1C
	} reg_addr_e;

	// Outcome of one bus access
	typedef enum logic {
		resp_ack = 1'b0,
		resp_err = 1'b1
	} wb_resp_e;

endpackage
